// File: cache_ctrl_pkg.sv
package cache_ctrl_pkg;

  import cache_geom_pkg::*;

  // core request, held until core_resp.
  typedef struct packed {
    logic  read;
    logic  write;
    addr_t addr;
    word_t wdata;
  } core_req_t;

  typedef struct packed {
    logic nmru_update;
    logic line_read;
    logic line_write;
    logic line_allocate;
    logic dirtytag_sel;   // ddr address from the victim tag.
    logic data_sel;       // ddr address from the request tag.
  } ctl_cmd_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    logic hit;
    tag_t tag;
  } way_status_t;

  // broadcast to every way, enables gated per way.
  typedef struct packed {
    index_t    index;
    tag_t      tag;
    word_sel_t word_sel;
    word_t     word;
    line_t     line;
    logic      alloc_en;
    logic      write_en;
  } way_write_t;

endpackage : cache_ctrl_pkg

// File: cache_geom_pkg.sv
package cache_geom_pkg;

  localparam int NUM_WAYS   = 2;  // ways per set.
  localparam int INDEX_W    = 4;  // 16 sets.
  localparam int OFFSET_W   = 5;  // 32-byte lines.
  localparam int LINE_WORDS = 8;

  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int NUM_SETS   = 1 << INDEX_W;
  localparam int WORD_SEL_W = $clog2(LINE_WORDS);
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
  localparam int LINE_W     = WORD_W * LINE_WORDS;
  localparam int WAY_W      = $clog2(NUM_WAYS);

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [WORD_SEL_W-1:0] word_sel_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [LINE_W-1:0]     line_t;  // word 0 in the low bits.
  typedef logic [WAY_W-1:0]      way_t;

endpackage : cache_geom_pkg

// File: l1cache.f
cache_geom_pkg.sv
cache_ctrl_pkg.sv
l1cache_control.sv
l1cache_datapath.sv
l1cache_way.sv
l1cache_way_select.sv
l1cache.sv
l1cache_tb.sv

// File: l1cache.sv
module l1cache import cache_geom_pkg::*, cache_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  core_req_t req,
  output logic      core_resp,
  output word_t     rdata,
  output logic      ddr_read,
  output logic      ddr_write,
  output addr_t     ddr_addr,
  output line_t     ddr_wdata,
  input  logic      ddr_resp,
  input  line_t     ddr_rdata
);

  ctl_cmd_t            cmd;
  logic                hit;
  logic                victim_dirty;
  way_write_t          wr;
  logic [NUM_WAYS-1:0] way_en;
  way_status_t         status [NUM_WAYS];
  line_t               lines  [NUM_WAYS];
  way_t                hit_way;
  way_t                victim_way;
  tag_t                victim_tag;
  line_t               victim_line;

  l1cache_control control0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .core_resp    (core_resp),
    .ddr_read     (ddr_read),
    .ddr_write    (ddr_write),
    .ddr_resp     (ddr_resp),
    .cmd          (cmd)
  );

  l1cache_datapath datapath0 (
    .req         (req),
    .cmd         (cmd),
    .ddr_rdata   (ddr_rdata),
    .hit_way     (hit_way),
    .victim_way  (victim_way),
    .victim_tag  (victim_tag),
    .victim_line (victim_line),
    .wr          (wr),
    .way_en      (way_en),
    .ddr_addr    (ddr_addr),
    .ddr_wdata   (ddr_wdata)
  );

  for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
    l1cache_way way0 (
      .clk    (clk),
      .rst_n  (rst_n),
      .wr     (wr),
      .en     (way_en[g]),
      .status (status[g]),
      .line   (lines[g])
    );
  end

  l1cache_way_select way_select0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .index        (wr.index),
    .word_sel     (wr.word_sel),
    .cmd          (cmd),
    .status       (status),
    .lines        (lines),
    .hit          (hit),
    .hit_way      (hit_way),
    .rdata        (rdata),
    .victim_way   (victim_way),
    .victim_tag   (victim_tag),
    .victim_line  (victim_line),
    .victim_dirty (victim_dirty)
  );

endmodule : l1cache

// File: l1cache_control.sv
module l1cache_control import cache_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  core_req_t req,
  input  logic      hit,
  input  logic      victim_dirty,
  output logic      core_resp,
  output logic      ddr_read,
  output logic      ddr_write,
  input  logic      ddr_resp,
  output ctl_cmd_t  cmd
);

  typedef enum logic [1:0] {
    idle,
    allocate,
    writeback
  } state_t;

  state_t state, next_state;
  logic   pending;

  assign pending = req.read | req.write;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    core_resp  = 1'b0;
    ddr_read   = 1'b0;
    ddr_write  = 1'b0;
    cmd        = '0;
    next_state = idle;

    case (state)
      idle: begin
        if (pending) begin
          if (hit) begin
            cmd.nmru_update = 1'b1;
            cmd.line_read   = req.read;
            cmd.line_write  = req.write;
            core_resp       = 1'b1;
          end else if (victim_dirty) begin
            ddr_write        = 1'b1;  // evict first.
            cmd.dirtytag_sel = 1'b1;
            next_state       = writeback;
          end else begin
            ddr_read     = 1'b1;
            cmd.data_sel = 1'b1;
            next_state   = allocate;
          end
        end
      end

      allocate: begin
        if (pending && !ddr_resp) begin
          ddr_read     = 1'b1;
          cmd.data_sel = 1'b1;
          next_state   = allocate;
        end else if (pending && ddr_resp) begin
          // line lands this edge, hit on the next cycle.
          cmd.data_sel      = 1'b1;
          cmd.line_allocate = 1'b1;
        end
      end

      writeback: begin
        if (pending && !ddr_resp) begin
          ddr_write        = 1'b1;
          cmd.dirtytag_sel = 1'b1;
          next_state       = writeback;
        end else if (pending && ddr_resp) begin
          ddr_read     = 1'b1;
          cmd.data_sel = 1'b1;
          next_state   = allocate;
        end
      end

      default: next_state = idle;
    endcase
  end

endmodule : l1cache_control

// File: l1cache_datapath.sv
module l1cache_datapath import cache_geom_pkg::*, cache_ctrl_pkg::*; (
  input  core_req_t           req,
  input  ctl_cmd_t            cmd,
  input  line_t               ddr_rdata,
  input  way_t                hit_way,
  input  way_t                victim_way,
  input  tag_t                victim_tag,
  input  line_t               victim_line,
  output way_write_t          wr,
  output logic [NUM_WAYS-1:0] way_en,
  output addr_t               ddr_addr,
  output line_t               ddr_wdata
);

  tag_t      req_tag;
  index_t    req_index;
  word_sel_t req_word;
  tag_t      line_tag;

  // address split.
  assign req_tag   = req.addr[ADDR_W-1 -: TAG_W];
  assign req_index = req.addr[OFFSET_W +: INDEX_W];
  assign req_word  = req.addr[OFFSET_W-1 -: WORD_SEL_W];

  always_comb begin
    wr.index    = req_index;
    wr.tag      = req_tag;
    wr.word_sel = req_word;
    wr.word     = req.wdata;
    wr.line     = ddr_rdata;  // fill data straight from ddr.
    wr.alloc_en = cmd.line_allocate;
    wr.write_en = cmd.line_write;
  end

  // store hits go to the hit way, fills to the victim.
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_en[w] = (cmd.line_write && (hit_way == way_t'(w))) ||
                  (cmd.line_allocate && (victim_way == way_t'(w)));
    end
  end

  assign line_tag = cmd.dirtytag_sel ? victim_tag : req_tag;

  always_comb begin
    if (cmd.dirtytag_sel || cmd.data_sel) begin
      ddr_addr = {line_tag, req_index, {OFFSET_W{1'b0}}};
    end else begin
      ddr_addr = '0;
    end
  end

  assign ddr_wdata = victim_line;  // only the victim is ever written back.

endmodule : l1cache_datapath

// File: l1cache_tb.sv
module l1cache_tb import cache_geom_pkg::*, cache_ctrl_pkg::*; ();

  logic      clk;
  logic      rst_n;
  core_req_t req;
  logic      core_resp;
  word_t     rdata;
  logic      ddr_read;
  logic      ddr_write;
  addr_t     ddr_addr;
  line_t     ddr_wdata;
  logic      ddr_resp;
  line_t     ddr_rdata;

  typedef struct packed {
    logic  is_wr;
    addr_t addr;
    line_t data;
  } ddr_ev_t;

  ddr_ev_t     exp_q [$];       // predicted ddr transfers, oldest first.
  line_t       ddr_mem [addr_t];
  word_t       shadow [addr_t];
  logic [31:0] lfsr;
  word_t       exp_rdata;
  addr_t       last_wb_addr;
  int          ddr_count;
  int          err_count;
  int          timeout_count;

  // reference cache state.
  logic rc_valid [NUM_SETS][NUM_WAYS];
  logic rc_dirty [NUM_SETS][NUM_WAYS];
  tag_t rc_tag   [NUM_SETS][NUM_WAYS];
  way_t rc_nmru  [NUM_SETS];

  l1cache dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .core_resp (core_resp),
    .rdata     (rdata),
    .ddr_read  (ddr_read),
    .ddr_write (ddr_write),
    .ddr_addr  (ddr_addr),
    .ddr_wdata (ddr_wdata),
    .ddr_resp  (ddr_resp),
    .ddr_rdata (ddr_rdata)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // taps 32 22 2 1.
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic word_t init_word(input addr_t a);
    return ((a ^ 32'ha5c3_0f96) * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic word_t ref_word(input addr_t a);
    return shadow.exists(a) ? shadow[a] : init_word(a);
  endfunction

  function automatic addr_t word_addr(input addr_t line_addr, input int k);
    return {line_addr[ADDR_W-1:OFFSET_W], k[WORD_SEL_W-1:0], 2'b00};
  endfunction

  function automatic line_t ref_line(input addr_t line_addr);
    line_t l;
    for (int k = 0; k < LINE_WORDS; k++) begin
      l[k*WORD_W +: WORD_W] = ref_word(word_addr(line_addr, k));
    end
    return l;
  endfunction

  // what the ddr side holds, never touched by the shadow.
  function automatic line_t mem_line(input addr_t line_addr);
    line_t l;
    if (ddr_mem.exists(line_addr)) begin
      return ddr_mem[line_addr];
    end
    for (int k = 0; k < LINE_WORDS; k++) begin
      l[k*WORD_W +: WORD_W] = init_word(word_addr(line_addr, k));
    end
    return l;
  endfunction

  function automatic addr_t make_addr(input tag_t t, input index_t i, input word_sel_t w);
    return {t, i, w, 2'b00};
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_line(input string name, input line_t got, input line_t exp);
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_traffic(input string what, input int start_count, input int exp);
    if (ddr_count - start_count != exp) begin
      err_count++;
      $display("%s saw %0d ddr transfers instead of %0d", what, ddr_count - start_count, exp);
    end
  endtask

  // walks the reference cache and queues the ddr transfers a miss needs.
  task automatic predict(input logic is_wr, input addr_t a);
    tag_t    t;
    index_t  i;
    int      way;
    logic    found;
    ddr_ev_t ev;
    t     = a[ADDR_W-1 -: TAG_W];
    i     = a[OFFSET_W +: INDEX_W];
    found = 1'b0;
    way   = 0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (rc_valid[i][w] && rc_tag[i][w] == t) begin
        found = 1'b1;
        way   = w;
      end
    end
    if (!found) begin
      way = !rc_valid[i][0] ? 0 : (!rc_valid[i][1] ? 1 : int'(rc_nmru[i]));
      if (rc_valid[i][way] && rc_dirty[i][way]) begin
        ev.is_wr = 1'b1;
        ev.addr  = {rc_tag[i][way], i, {OFFSET_W{1'b0}}};
        ev.data  = ref_line(ev.addr);
        exp_q.push_back(ev);
      end
      ev.is_wr = 1'b0;
      ev.addr  = {t, i, {OFFSET_W{1'b0}}};
      ev.data  = '0;
      exp_q.push_back(ev);
      rc_valid[i][way] = 1'b1;
      rc_dirty[i][way] = 1'b0;
      rc_tag[i][way]   = t;
    end
    if (is_wr) begin
      rc_dirty[i][way] = 1'b1;
    end
    rc_nmru[i] = (way == 0) ? 1'b1 : 1'b0;
  endtask

  task automatic access(input logic is_wr, input addr_t a, input word_t d);
    int   cycles;
    logic seen;
    @(negedge clk);
    predict(is_wr, a);
    exp_rdata = ref_word(a);
    req.read  = !is_wr;
    req.write = is_wr;
    req.addr  = a;
    req.wdata = d;
    cycles    = 0;
    seen      = 1'b0;
    while (!seen && cycles < 200) begin
      @(posedge clk);
      seen = core_resp;
      cycles++;
    end
    if (!seen) begin
      timeout_count++;
      $display("no core_resp within 200 cycles for address %h", a);
    end
    if (is_wr) begin
      shadow[a] = d;
    end
    if (exp_q.size() != 0) begin
      err_count++;
      $display("%0d predicted ddr transfers missing at %0t", exp_q.size(), $time);
      exp_q.delete();
    end
    @(negedge clk);
    req = '0;
  endtask

  always @(posedge clk) begin
    if (rst_n && core_resp && req.read) begin
      check_word("rdata", rdata, exp_rdata);
    end
  end

  initial begin : ddr_model
    int      delay;
    ddr_ev_t ev;
    line_t   fill;
    forever begin
      @(posedge clk);
      if (rst_n && (ddr_read || ddr_write)) begin
        if (ddr_read && ddr_write) begin
          err_count++;
          $display("ddr_read and ddr_write high together at %0t", $time);
        end
        ddr_count++;
        if (exp_q.size() == 0) begin
          err_count++;
          $display("unexpected ddr transfer to %h at %0t", ddr_addr, $time);
        end else begin
          ev = exp_q.pop_front();
          if (ev.is_wr !== ddr_write) begin
            err_count++;
            $display("ddr transfer to %h goes the wrong direction", ddr_addr);
          end
          check_addr("ddr_addr", ddr_addr, ev.addr);
          if (ddr_write) begin
            check_line("ddr_wdata", ddr_wdata, ev.data);
          end
        end
        fill = mem_line(ddr_addr);
        if (ddr_write) begin
          ddr_mem[ddr_addr] = ddr_wdata;
          last_wb_addr      = ddr_addr;
        end
        delay = int'(take_bits(3)) % 6 + 1;
        repeat (delay) @(negedge clk);
        ddr_rdata = fill;
        ddr_resp  = 1'b1;
        @(negedge clk);
        ddr_resp  = 1'b0;
      end
    end
  end

  initial begin
    addr_t       a0, x, y, z, a, b, c;
    logic [31:0] bits;
    int          count;
    lfsr          = 32'hc371d5a4;
    err_count     = 0;
    timeout_count = 0;
    ddr_count     = 0;
    last_wb_addr  = '0;
    exp_rdata     = '0;
    req           = '0;
    ddr_resp      = 1'b0;
    ddr_rdata     = '0;
    rst_n         = 1'b0;
    for (int s = 0; s < NUM_SETS; s++) begin
      rc_nmru[s] = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        rc_valid[s][w] = 1'b0;
        rc_dirty[s][w] = 1'b0;
        rc_tag[s][w]   = '0;
      end
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    a0 = make_addr(23'h10, 4'd5, 3'd3);
    count = ddr_count;
    access(1'b0, a0, '0);
    check_traffic("clean read miss", count, 1);
    count = ddr_count;
    access(1'b0, make_addr(23'h10, 4'd5, 3'd6), '0);
    access(1'b1, a0, 32'hcafe_0123);
    access(1'b0, a0, '0);
    check_traffic("hits in a filled line", count, 0);

    // x dirty in way 0, z then evicts it.
    x = make_addr(23'h21, 4'd7, 3'd0);
    y = make_addr(23'h22, 4'd7, 3'd2);
    z = make_addr(23'h23, 4'd7, 3'd4);
    access(1'b1, x, 32'h1357_9bdf);
    access(1'b0, y, '0);
    count = ddr_count;
    access(1'b0, z, '0);
    check_traffic("dirty eviction", count, 2);
    check_addr("ddr_addr", last_wb_addr, {x[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});

    a = make_addr(23'h31, 4'd9, 3'd1);
    b = make_addr(23'h32, 4'd9, 3'd5);
    c = make_addr(23'h33, 4'd9, 3'd7);
    access(1'b0, a, '0);
    access(1'b1, b, 32'h2468_ace0);
    access(1'b0, a, '0);
    count = ddr_count;
    access(1'b0, c, '0);
    check_traffic("nmru eviction", count, 2);
    check_addr("ddr_addr", last_wb_addr, {b[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
    count = ddr_count;
    access(1'b0, a, '0);
    check_traffic("kept line", count, 0);

    // 4 tags, sets 2 6 10 14, 4 words per line.
    for (int n = 0; n < 300; n++) begin
      bits = take_bits(7);
      access(bits[6], make_addr(tag_t'(23'h40 + bits[1:0]), {bits[3:2], 2'b10},
             {bits[5:4], 1'b1}), take_bits(32));
    end

    $display("value errors: %0d, timeouts: %0d", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : l1cache_tb

// File: l1cache_way.sv
module l1cache_way import cache_geom_pkg::*, cache_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  way_write_t  wr,
  input  logic        en,
  output way_status_t status,
  output line_t       line
);

  logic  valid_q [NUM_SETS];
  logic  dirty_q [NUM_SETS];
  tag_t  tag_q   [NUM_SETS];
  line_t data_q  [NUM_SETS];

  // state bits.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= 1'b0;
        dirty_q[s] <= 1'b0;
      end
    end else if (en) begin
      if (wr.alloc_en) begin
        valid_q[wr.index] <= 1'b1;
        dirty_q[wr.index] <= 1'b0;  // fresh fill is clean.
      end else if (wr.write_en) begin
        dirty_q[wr.index] <= 1'b1;
      end
    end
  end

  // tag and data arrays.
  always_ff @(posedge clk) begin
    if (en) begin
      if (wr.alloc_en) begin
        tag_q[wr.index]  <= wr.tag;
        data_q[wr.index] <= wr.line;
      end else if (wr.write_en) begin
        data_q[wr.index][wr.word_sel*WORD_W +: WORD_W] <= wr.word;
      end
    end
  end

  always_comb begin
    status.valid = valid_q[wr.index];
    status.dirty = dirty_q[wr.index];
    status.tag   = tag_q[wr.index];
    status.hit   = valid_q[wr.index] && (tag_q[wr.index] == wr.tag);
  end

  assign line = data_q[wr.index];

endmodule : l1cache_way

// File: l1cache_way_select.sv
module l1cache_way_select import cache_geom_pkg::*, cache_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  index_t      index,
  input  word_sel_t   word_sel,
  input  ctl_cmd_t    cmd,
  input  way_status_t status [NUM_WAYS],
  input  line_t       lines  [NUM_WAYS],
  output logic        hit,
  output way_t        hit_way,
  output word_t       rdata,
  output way_t        victim_way,
  output tag_t        victim_tag,
  output line_t       victim_line,
  output logic        victim_dirty
);

  way_t  nmru_q [NUM_SETS];
  logic  found_invalid;
  line_t hit_line;

  // hit detection.
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (status[w].hit) begin
        hit     = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  assign hit_line = lines[hit_way];
  assign rdata    = cmd.line_read ? hit_line[word_sel*WORD_W +: WORD_W] : '0;

  // point the set at the way not just used.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        nmru_q[s] <= '0;
      end
    end else if (cmd.nmru_update) begin
      nmru_q[index] <= ~hit_way;
    end
  end

  // lowest invalid way wins, else the nmru way.
  always_comb begin
    found_invalid = 1'b0;
    victim_way    = nmru_q[index];
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!found_invalid && !status[w].valid) begin
        found_invalid = 1'b1;
        victim_way    = way_t'(w);
      end
    end
  end

  assign victim_tag   = status[victim_way].tag;
  assign victim_line  = lines[victim_way];
  assign victim_dirty = status[victim_way].valid && status[victim_way].dirty;

endmodule : l1cache_way_select

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f l1cache.f --top-module l1cache_tb
./obj_dir/Vl1cache_tb | tee sim.log

if grep -qF '** FAIL **' sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation finished without failures"
